/* dv/pipe_core_tb.sv */
module pipe_core_tb;

    localparam int MAX_CYCLES = 512;
    localparam int MAX_TESTS  = 32;

    logic             clk;
    logic             rst_n;
    logic             stallreq_pc;
    logic             stallreq_if;
    logic             stallreq_id;
    logic             stallreq_ex;
    logic             stallreq_mem;
    pipe_pkg::word_t  excepttype;
    pipe_pkg::word_t  cp0_epc;
    pipe_pkg::stall_t stall;
    logic             flush;
    pipe_pkg::word_t  new_pc;
    logic             retire_valid;
    pipe_pkg::word_t  retire_pc;
    pipe_pkg::count_t retire_count;

    // one entry per stim cycle, request bits ordered pc, if, id, ex, mem
    logic [4:0]       req_tab    [0:MAX_CYCLES-1];
    pipe_pkg::word_t  exc_tab    [0:MAX_CYCLES-1];
    pipe_pkg::word_t  epc_tab    [0:MAX_CYCLES-1];
    pipe_pkg::stall_t stall_tab  [0:MAX_CYCLES-1];
    logic             flush_tab  [0:MAX_CYCLES-1];
    pipe_pkg::word_t  new_pc_tab [0:MAX_CYCLES-1];
    logic             rv_tab     [0:MAX_CYCLES-1];
    pipe_pkg::word_t  rpc_tab    [0:MAX_CYCLES-1];
    pipe_pkg::count_t count_tab  [0:MAX_CYCLES-1];
    int               test_tab   [0:MAX_CYCLES-1];
    string            test_names [0:MAX_TESTS-1];

    int num_cycles;
    int num_tests;
    int cycle_limit;
    int cycle_count;
    int test_errors;
    int test_len;
    int tests_run;
    int tests_failed;
    int total_errors;
    bit loaded;

    pipe_core dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .stallreq_pc  (stallreq_pc),
        .stallreq_if  (stallreq_if),
        .stallreq_id  (stallreq_id),
        .stallreq_ex  (stallreq_ex),
        .stallreq_mem (stallreq_mem),
        .excepttype   (excepttype),
        .cp0_epc      (cp0_epc),
        .stall        (stall),
        .flush        (flush),
        .new_pc       (new_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_count (retire_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic load_stim(output bit ok);
        int          fd;
        int          n;
        string       line;
        string       tok;
        string       name;
        logic [31:0] v_pc, v_if, v_id, v_ex, v_mem;
        logic [31:0] v_exc, v_epc, v_flush, v_new_pc, v_rv, v_rpc, v_cnt;
        logic [5:0]  v_stall;
        ok = 1'b1;
        num_cycles = 0;
        num_tests = 0;
        fd = $fopen("dv/pipe_stim.txt", "r");
        if (fd == 0)
        begin
            $display("error: stim file dv/pipe_stim.txt could not be opened");
            ok = 1'b0;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                tok = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s", tok);
                if (n >= 1 && tok.substr(0, 0) != "#")
                begin
                    if (tok == "test" && num_tests < MAX_TESTS)
                    begin
                        n = $sscanf(line, "%s %s", tok, name);
                        test_names[num_tests] = name;
                        num_tests++;
                    end
                    else
                    begin
                        n = $sscanf(line, "%h %h %h %h %h %h %h %b %h %h %h %h %h",
                                    v_pc, v_if, v_id, v_ex, v_mem, v_exc, v_epc,
                                    v_stall, v_flush, v_new_pc, v_rv, v_rpc, v_cnt);
                        if (n != 13 || num_tests == 0 || num_cycles >= MAX_CYCLES)
                        begin
                            $display("error: stim line could not be read: %s", line);
                            ok = 1'b0;
                        end
                        else
                        begin
                            req_tab[num_cycles]    = {v_mem[0], v_ex[0], v_id[0],
                                                      v_if[0], v_pc[0]};
                            exc_tab[num_cycles]    = v_exc;
                            epc_tab[num_cycles]    = v_epc;
                            stall_tab[num_cycles]  = v_stall;
                            flush_tab[num_cycles]  = v_flush[0];
                            new_pc_tab[num_cycles] = v_new_pc;
                            rv_tab[num_cycles]     = v_rv[0];
                            rpc_tab[num_cycles]    = v_rpc;
                            count_tab[num_cycles]  = v_cnt;
                            test_tab[num_cycles]   = num_tests - 1;
                            num_cycles++;
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_inputs(input int i);
        stallreq_pc  = req_tab[i][0];
        stallreq_if  = req_tab[i][1];
        stallreq_id  = req_tab[i][2];
        stallreq_ex  = req_tab[i][3];
        stallreq_mem = req_tab[i][4];
        excepttype   = exc_tab[i];
        cp0_epc      = epc_tab[i];
    endtask

    task automatic compare_value(input int i, input string sig,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch test=%s cycle=%0d signal=%s expected=%h actual=%h",
                     test_names[test_tab[i]], i, sig, expected, actual);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic check_outputs(input int i);
        compare_value(i, "stall", 32'(stall_tab[i]), 32'(stall));
        compare_value(i, "flush", 32'(flush_tab[i]), 32'(flush));
        compare_value(i, "new_pc", new_pc_tab[i], new_pc);
        compare_value(i, "retire_valid", 32'(rv_tab[i]), 32'(retire_valid));
        compare_value(i, "retire_pc", rpc_tab[i], retire_pc);
        compare_value(i, "retire_count", count_tab[i], retire_count);
    endtask

    task automatic report_test(input int t);
        tests_run++;
        if (test_errors == 0)
            $display("test %s: ok, %0d cycles", test_names[t], test_len);
        else
        begin
            $display("test %s: %0d errors in %0d cycles", test_names[t], test_errors, test_len);
            tests_failed++;
        end
    endtask

    // watchdog, armed once the stim length is known
    initial
    begin
        wait (loaded);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("error: run did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        bit ok;
        int cur;
        rst_n        = 1'b0;
        stallreq_pc  = 1'b0;
        stallreq_if  = 1'b0;
        stallreq_id  = 1'b0;
        stallreq_ex  = 1'b0;
        stallreq_mem = 1'b0;
        excepttype   = '0;
        cp0_epc      = '0;
        load_stim(ok);
        if (!ok)
        begin
            $display("TESTS FAILED");
            $finish;
        end
        else
        begin
            cycle_limit = num_cycles + 50;
            loaded = 1'b1;
            repeat (3) @(posedge clk);
            #1;
            rst_n = 1'b1;
            cur = -1;
            for (int i = 0; i < num_cycles; i++)
            begin
                if (test_tab[i] != cur)
                begin
                    if (cur >= 0)
                        report_test(cur);
                    cur = test_tab[i];
                    test_errors = 0;
                    test_len = 0;
                end
                drive_inputs(i);
                // registered outputs settled, sample just before the edge
                #6;
                check_outputs(i);
                test_len++;
                @(posedge clk);
                #1;
            end
            if (cur >= 0)
                report_test(cur);
            $display("summary: %0d tests run, %0d ok, %0d failing, %0d mismatches",
                     tests_run, tests_run - tests_failed, tests_failed, total_errors);
            if (tests_failed == 0 && total_errors == 0)
                $display("TESTS PASSED");
            else
                $display("TESTS FAILED");
            $finish;
        end
    end

endmodule

/* dv/pipe_stim.txt */
# in:  stallreq pc if id ex mem, excepttype, cp0_epc
# exp: stall (binary), flush, new_pc, retire_valid, retire_pc, retire_count (hex)
test reset_run
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 00000000 00
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 00000000 00
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 00000000 00
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 00000000 00
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 00000000 00
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 00000000 00
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00004 01
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00008 02
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc0000c 03
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00010 04
# held MEM/WB entry is sampled again by retire
test stall_priority
1 0 1 0 1 00000000 00000000 011110 0 00000000 1 bfc00014 05
1 1 1 1 0 00000000 00000000 001110 0 00000000 1 bfc00018 06
1 1 1 0 0 00000000 00000000 000110 0 00000000 1 bfc00018 07
1 1 0 0 0 00000000 00000000 000010 0 00000000 0 bfc00018 07
1 0 0 0 0 00000000 00000000 000001 0 00000000 1 bfc0001c 08
test bubbles_hold
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc0001c 08
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00020 09
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00020 09
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00024 0a
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00024 0a
0 0 0 1 0 00000000 00000000 001110 0 00000000 1 bfc00028 0b
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc0002c 0c
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc0002c 0c
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00030 0d
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00034 0e
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00038 0f
# EXC_SYS, then the handler entry drains through
test exc_vector
0 0 0 0 0 00000008 00000000 000000 1 bfc00380 1 bfc0003c 10
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00040 11
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00040 11
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00040 11
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00040 11
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00040 11
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00380 12
# EXC_INT, ADEL, ADES, BP, RI, OV, TR back to back
test exc_codes
0 0 0 0 0 00000001 00000000 000000 1 bfc00380 1 bfc00384 13
0 0 0 0 0 00000004 00000000 000000 1 bfc00380 1 bfc00388 14
0 0 0 0 0 00000005 00000000 000000 1 bfc00380 0 bfc00388 14
0 0 0 0 0 00000009 00000000 000000 1 bfc00380 0 bfc00388 14
0 0 0 0 0 0000000a 00000000 000000 1 bfc00380 0 bfc00388 14
0 0 0 0 0 0000000c 00000000 000000 1 bfc00380 0 bfc00388 14
0 0 0 0 0 0000000d 00000000 000000 1 bfc00380 0 bfc00388 14
test eret
0 0 0 0 0 0000000e 80001230 000000 1 80001230 0 bfc00388 14
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00388 14
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00388 14
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00388 14
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00388 14
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 bfc00388 14
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 80001230 15
# ADES beats a MEM stall, codes 7, 3 and ff are unknown
test exc_override
0 0 0 0 1 00000005 00000000 000000 1 bfc00380 1 80001234 16
0 0 0 1 1 00000007 00000000 011110 0 00000000 1 80001238 17
0 0 1 0 0 00000003 00000000 000110 0 00000000 0 80001238 17
0 0 0 0 0 000000ff 00000000 000000 0 00000000 0 80001238 17
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 80001238 17
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 80001238 17
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 80001238 17
0 0 0 0 0 00000000 00000000 000000 0 00000000 0 80001238 17
0 0 0 0 0 00000000 00000000 000000 0 00000000 1 bfc00380 18

/* pipe_ctrl.f */
source/pipe_pkg.sv
source/pipe_ctrl.sv
source/fetch_pc.sv
source/stage_reg.sv
source/retire_unit.sv
source/pipe_core.sv
dv/pipe_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pipe_core_tb \
    -Mdir obj_dir -o pipe_core_sim \
    -f pipe_ctrl.f

sim_out="$(./obj_dir/pipe_core_sim)"
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"
then
    exit 0
fi
exit 1

/* source/fetch_pc.sv */
module fetch_pc #(
    parameter pipe_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  pipe_pkg::stall_t stall,
    input  logic             flush,
    input  pipe_pkg::word_t  new_pc,
    output pipe_pkg::word_t  pc,
    output logic             pc_valid
);

    logic hold;

    // IF stall vectors leave bit 0 clear, so a held IF
    // register must also freeze pc or the next fetch is lost
    assign hold = stall[pipe_pkg::STALL_PC] | stall[pipe_pkg::STALL_IF];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc       <= RESET_PC;
            pc_valid <= 1'b0;
        end
        else
        begin
            pc_valid <= 1'b1;
            if (flush)
            begin
                pc <= new_pc;
            end
            else if (!hold)
            begin
                pc <= pc + 32'd4;
            end
        end
    end

    // redirect targets come from outside, keep them aligned
    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00
    ) else $error("fetch pc %h is not word aligned", pc);

endmodule

/* source/pipe_core.sv */
module pipe_core #(
    parameter pipe_pkg::word_t RESET_PC = 32'hbfc0_0000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stallreq_pc,
    input  logic              stallreq_if,
    input  logic              stallreq_id,
    input  logic              stallreq_ex,
    input  logic              stallreq_mem,
    input  pipe_pkg::word_t   excepttype,
    input  pipe_pkg::word_t   cp0_epc,
    output pipe_pkg::stall_t  stall,
    output logic              flush,
    output pipe_pkg::word_t   new_pc,
    output logic              retire_valid,
    output pipe_pkg::word_t   retire_pc,
    output pipe_pkg::count_t  retire_count
);

    // index 0 is the fetch pc, 1..NUM_STAGES the pipeline registers
    pipe_pkg::word_t  stage_pc    [0:pipe_pkg::NUM_STAGES];
    logic             stage_valid [0:pipe_pkg::NUM_STAGES];

    pipe_ctrl u_ctrl (
        .rst_n        (rst_n),
        .stallreq_pc  (stallreq_pc),
        .stallreq_if  (stallreq_if),
        .stallreq_id  (stallreq_id),
        .stallreq_ex  (stallreq_ex),
        .stallreq_mem (stallreq_mem),
        .excepttype   (excepttype),
        .cp0_epc      (cp0_epc),
        .stall        (stall),
        .flush        (flush),
        .new_pc       (new_pc)
    );

    fetch_pc #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .new_pc   (new_pc),
        .pc       (stage_pc[0]),
        .pc_valid (stage_valid[0])
    );

    // IF/ID, ID/EX, EX/MEM, MEM/WB
    generate
        for (genvar k = 1; k <= pipe_pkg::NUM_STAGES; k++)
        begin : g_stage
            stage_reg #(
                .STAGE (k)
            ) u_stage (
                .clk       (clk),
                .rst_n     (rst_n),
                .stall     (stall),
                .flush     (flush),
                .in_pc     (stage_pc[k - 1]),
                .in_valid  (stage_valid[k - 1]),
                .out_pc    (stage_pc[k]),
                .out_valid (stage_valid[k])
            );
        end
    endgenerate

    retire_unit u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_pc        (stage_pc[pipe_pkg::NUM_STAGES]),
        .in_valid     (stage_valid[pipe_pkg::NUM_STAGES]),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_count (retire_count)
    );

endmodule

/* source/pipe_ctrl.sv */
module pipe_ctrl (
    input  logic             rst_n,
    input  logic             stallreq_pc,
    input  logic             stallreq_if,
    input  logic             stallreq_id,
    input  logic             stallreq_ex,
    input  logic             stallreq_mem,
    input  pipe_pkg::word_t  excepttype,
    input  pipe_pkg::word_t  cp0_epc,
    output pipe_pkg::stall_t stall,
    output logic             flush,
    output pipe_pkg::word_t  new_pc
);

    logic              exc_hit;
    pipe_pkg::word_t   exc_target;
    pipe_pkg::stall_t  stall_run;

    // decode the MEM stage exception code
    always_comb
    begin
        exc_hit    = 1'b1;
        exc_target = pipe_pkg::EXC_VECTOR;
        case (excepttype)
            pipe_pkg::EXC_INT, pipe_pkg::EXC_ADEL, pipe_pkg::EXC_ADES,
            pipe_pkg::EXC_SYS, pipe_pkg::EXC_BP, pipe_pkg::EXC_RI,
            pipe_pkg::EXC_OV, pipe_pkg::EXC_TR:
                exc_target = pipe_pkg::EXC_VECTOR;
            pipe_pkg::EXC_ERET:
                exc_target = cp0_epc;
            // unknown codes behave as no exception
            pipe_pkg::EXC_NONE:
                exc_hit = 1'b0;
            default:
                exc_hit = 1'b0;
        endcase
    end

    // exception first, then the oldest stalling stage wins
    always_comb
    begin
        stall  = '0;
        flush  = 1'b0;
        new_pc = '0;
        if (rst_n)
        begin
            if (exc_hit)
            begin
                flush  = 1'b1;
                new_pc = exc_target;
            end
            else if (stallreq_mem)
                stall[pipe_pkg::STALL_MEM:pipe_pkg::STALL_IF] = '1;
            else if (stallreq_ex)
                stall[pipe_pkg::STALL_EX:pipe_pkg::STALL_IF] = '1;
            else if (stallreq_id)
                stall[pipe_pkg::STALL_ID:pipe_pkg::STALL_IF] = '1;
            else if (stallreq_if)
                stall[pipe_pkg::STALL_IF] = 1'b1;
            else if (stallreq_pc)
                stall[pipe_pkg::STALL_PC] = 1'b1;
        end
    end

    // stall must be a run of ones from bit 0 or bit 1
    always_comb
    begin
        stall_run = stall[pipe_pkg::STALL_PC] ? stall : (stall >> 1);
        assert (!(flush && stall != '0))
            else $error("flush raised together with stall %b", stall);
        assert ((stall_run & (stall_run + 1'b1)) == '0)
            else $error("stall vector %b is not a contiguous prefix", stall);
    end

endmodule

/* source/pipe_pkg.sv */
package pipe_pkg;

    // one machine word: pc, epc, redirect target, exception code
    typedef logic [31:0] word_t;

    // stall vector, one bit per stage from pc up to WB
    typedef logic [5:0] stall_t;

    // retired instruction count
    typedef logic [31:0] count_t;

    // stall bit positions
    localparam int unsigned STALL_PC  = 0;
    localparam int unsigned STALL_IF  = 1;
    localparam int unsigned STALL_ID  = 2;
    localparam int unsigned STALL_EX  = 3;
    localparam int unsigned STALL_MEM = 4;
    localparam int unsigned STALL_WB  = 5;

    // pipeline registers between IF and WB
    localparam int unsigned NUM_STAGES = 4;

    // exception codes from the MEM stage
    localparam word_t EXC_NONE = 32'h0000_0000;
    localparam word_t EXC_INT  = 32'h0000_0001;
    localparam word_t EXC_ADEL = 32'h0000_0004;
    localparam word_t EXC_ADES = 32'h0000_0005;
    localparam word_t EXC_SYS  = 32'h0000_0008;
    localparam word_t EXC_BP   = 32'h0000_0009;
    localparam word_t EXC_RI   = 32'h0000_000a;
    localparam word_t EXC_OV   = 32'h0000_000c;
    localparam word_t EXC_TR   = 32'h0000_000d;
    localparam word_t EXC_ERET = 32'h0000_000e;

    // common handler entry for every exception except eret
    localparam word_t EXC_VECTOR = 32'hbfc0_0380;

endpackage

/* source/retire_unit.sv */
module retire_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::word_t   in_pc,
    input  logic              in_valid,
    output logic              retire_valid,
    output pipe_pkg::word_t   retire_pc,
    output pipe_pkg::count_t  retire_count
);

    // one-cycle pulse per completing instruction
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            retire_valid <= 1'b0;
        end
        else
        begin
            retire_valid <= in_valid;
        end
    end

    // last retired pc and running total
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            retire_pc    <= '0;
            retire_count <= '0;
        end
        else if (in_valid)
        begin
            retire_pc    <= in_pc;
            retire_count <= retire_count + 1'b1;
        end
    end

endmodule

/* source/stage_reg.sv */
module stage_reg #(
    parameter int unsigned STAGE = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  pipe_pkg::stall_t stall,
    input  logic             flush,
    input  pipe_pkg::word_t  in_pc,
    input  logic             in_valid,
    output pipe_pkg::word_t  out_pc,
    output logic             out_valid
);

    logic stall_up;
    logic stall_own;

    // upstream stage sits one bit below this one
    assign stall_up  = stall[STAGE - 1];
    assign stall_own = stall[STAGE];

    // valid bit
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
        end
        else if (flush)
        begin
            out_valid <= 1'b0;
        end
        else if (!stall_own)
        begin
            // bubble when upstream is frozen
            out_valid <= stall_up ? 1'b0 : in_valid;
        end
    end

    // pc payload, only meaningful while valid
    always_ff @(posedge clk)
    begin
        if (!flush && !stall_own && !stall_up)
        begin
            out_pc <= in_pc;
        end
    end

    flush_clears: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid
    ) else $error("stage %0d still valid after flush", STAGE);

endmodule
